/* logic/gen_params.svh */
/*
 * generator channel widths, table depth
 * and register byte offsets
 */
`ifndef GEN_PARAMS_SVH
`define GEN_PARAMS_SVH

// sample and table geometry
`define GEN_DW   14
`define GEN_CWM  10
`define GEN_CWF  16
`define GEN_CW   (`GEN_CWM+`GEN_CWF)
// gain, signed with 14 fraction bits
`define GEN_MW   16
// register port
`define GEN_AW   7
// burst counters
`define GEN_CWL  32
`define GEN_CWN  16

`define GEN_A_CTL  7'h00
`define GEN_A_IEN  7'h08
`define GEN_A_IST  7'h0c
`define GEN_A_MRST 7'h10
`define GEN_A_MSTR 7'h14
`define GEN_A_MSTP 7'h18
`define GEN_A_MTRG 7'h1c
`define GEN_A_SIZ  7'h20
`define GEN_A_OFF  7'h24
`define GEN_A_STE  7'h28
`define GEN_A_BMD  7'h30
`define GEN_A_BDL  7'h34
`define GEN_A_BLN  7'h38
`define GEN_A_BNM  7'h3c
`define GEN_A_SBL  7'h40
`define GEN_A_SBN  7'h44
`define GEN_A_MUL  7'h50
`define GEN_A_SUM  7'h54
`define GEN_A_ENA  7'h58

`endif

/* logic/gen_pkg.sv */
/*
 * types shared by the generator channel
 * sample, event, configuration, status and stream payload
 */
`include "gen_params.svh"

package gen_pkg;

  // signed DAC sample
  typedef logic signed [`GEN_DW-1:0] gen_smp_t;

  // event pulses, rst sits in bit 0
  typedef struct packed {
    logic trg;
    logic stp;
    logic str;
    logic rst;
  } gen_evt_t;

  // event output, software pulses plus engine events
  typedef struct packed {
    logic lst;  // last sample of last burst
    logic per;  // period or burst wrap
    logic trg;
    logic stp;
    logic str;
    logic rst;
  } gen_evo_t;

  typedef struct packed {
    // table walk, fixed point
    logic [`GEN_CW-1:0]  siz;
    logic [`GEN_CW-1:0]  off;
    logic [`GEN_CW-1:0]  ste;
    // burst shape
    logic                ben;
    logic                inf;
    logic [`GEN_CWM-1:0] bdl;
    logic [`GEN_CWL-1:0] bln;
    logic [`GEN_CWN-1:0] bnm;
    // linear stage
    logic [`GEN_MW-1:0]  mul;
    gen_smp_t            sum;
    logic                ena;
  } gen_cfg_t;

  typedef struct packed {
    logic                run;  // data or idle gap phase
    logic                trg;  // armed, waiting for trigger
    logic [`GEN_CWL-1:0] bln;  // idle gap cycle counter
    logic [`GEN_CWN-1:0] bnm;  // finished bursts
  } gen_sts_t;

  // stream payload, valid/ready travel beside it
  typedef struct packed {
    gen_smp_t dat;
    logic     lst;
  } gen_stm_t;

endpackage

/* logic/gen_regs.sv */
/*
 * register block of the generator channel
 * config decode, event masks, software pulses,
 * interrupt status and registered read data
 */
`timescale 1ns/1ps
`include "gen_params.svh"

module gen_regs (
  input  logic                 bus,
  input  logic                 ctl_rst,
  // register port
  input  logic                 reg_wen,
  input  logic                 reg_ren,
  input  logic [`GEN_AW-1:0]   reg_addr,
  input  logic [32-1:0]        reg_wdata,
  output logic [32-1:0]        reg_rdata,
  output logic                 reg_ack,
  // events
  input  gen_pkg::gen_evt_t    evi,
  input  gen_pkg::gen_sts_t    sts,
  input  logic                 per,
  input  logic                 lst,
  output gen_pkg::gen_cfg_t    cfg,
  output gen_pkg::gen_evt_t    ctl,
  output gen_pkg::gen_evo_t    evo,
  output logic                 irq
);
  import gen_pkg::*;

  // select masks, bit 0 external, bit 1 software
  logic [4-1:0] msk_rst;
  logic [4-1:0] msk_str;
  logic [4-1:0] msk_stp;
  logic [4-1:0] msk_trg;
  // interrupts, bit order matches gen_evt_t
  logic [4-1:0] irq_ena;
  logic [4-1:0] irq_sts;
  logic [4-1:0] irq_clr;
  // software pulses from the control register
  gen_evt_t     swp;

  ////////////////////
  // bus side
  ////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      reg_ack <= 1'b0;
    end else begin
      reg_ack <= reg_wen | reg_ren;
    end
  end

  // writes, each field masked to its width
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      cfg     <= '0;
      irq_ena <= '0;
      msk_rst <= '0;
      msk_str <= '0;
      msk_stp <= '0;
      msk_trg <= '0;
    end else if (reg_wen) begin
      case (reg_addr)
        `GEN_A_IEN:  irq_ena <= reg_wdata[4-1:0];
        `GEN_A_MRST: msk_rst <= reg_wdata[4-1:0];
        `GEN_A_MSTR: msk_str <= reg_wdata[4-1:0];
        `GEN_A_MSTP: msk_stp <= reg_wdata[4-1:0];
        `GEN_A_MTRG: msk_trg <= reg_wdata[4-1:0];
        `GEN_A_SIZ:  cfg.siz <= reg_wdata[`GEN_CW-1:0];
        `GEN_A_OFF:  cfg.off <= reg_wdata[`GEN_CW-1:0];
        `GEN_A_STE:  cfg.ste <= reg_wdata[`GEN_CW-1:0];
        `GEN_A_BMD: begin
          cfg.ben <= reg_wdata[0];
          cfg.inf <= reg_wdata[1];
        end
        `GEN_A_BDL:  cfg.bdl <= reg_wdata[`GEN_CWM-1:0];
        `GEN_A_BLN:  cfg.bln <= reg_wdata[`GEN_CWL-1:0];
        `GEN_A_BNM:  cfg.bnm <= reg_wdata[`GEN_CWN-1:0];
        `GEN_A_MUL:  cfg.mul <= reg_wdata[`GEN_MW-1:0];
        `GEN_A_SUM:  cfg.sum <= reg_wdata[`GEN_DW-1:0];
        `GEN_A_ENA:  cfg.ena <= reg_wdata[0];
        default: ;
      endcase
    end
  end

  // read data lands together with the ack
  always_ff @(posedge bus) begin
    if (reg_ren) begin
      case (reg_addr)
        `GEN_A_CTL:  reg_rdata <= 32'({sts.trg, sts.run});
        `GEN_A_IEN:  reg_rdata <= 32'(irq_ena);
        `GEN_A_IST:  reg_rdata <= 32'(irq_sts);
        `GEN_A_MRST: reg_rdata <= 32'(msk_rst);
        `GEN_A_MSTR: reg_rdata <= 32'(msk_str);
        `GEN_A_MSTP: reg_rdata <= 32'(msk_stp);
        `GEN_A_MTRG: reg_rdata <= 32'(msk_trg);
        `GEN_A_SIZ:  reg_rdata <= 32'(cfg.siz);
        `GEN_A_OFF:  reg_rdata <= 32'(cfg.off);
        `GEN_A_STE:  reg_rdata <= 32'(cfg.ste);
        `GEN_A_BMD:  reg_rdata <= 32'({cfg.inf, cfg.ben});
        `GEN_A_BDL:  reg_rdata <= 32'(cfg.bdl);
        `GEN_A_BLN:  reg_rdata <= 32'(cfg.bln);
        `GEN_A_BNM:  reg_rdata <= 32'(cfg.bnm);
        // live burst counters
        `GEN_A_SBL:  reg_rdata <= 32'(sts.bln);
        `GEN_A_SBN:  reg_rdata <= 32'(sts.bnm);
        `GEN_A_MUL:  reg_rdata <= 32'(cfg.mul);
        // offset reads back zero extended
        `GEN_A_SUM:  reg_rdata <= {{(32-`GEN_DW){1'b0}}, cfg.sum};
        `GEN_A_ENA:  reg_rdata <= 32'(cfg.ena);
        default:     reg_rdata <= '0;
      endcase
    end
  end

  ////////////////////
  // events
  ////////////////////

  // one cycle pulse per control write
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      swp <= '0;
    end else if (reg_wen && (reg_addr == `GEN_A_CTL)) begin
      swp <= gen_evt_t'(reg_wdata[4-1:0]);
    end else begin
      swp <= '0;
    end
  end

  // masked sources, or-reduced per event
  always_comb begin
    ctl.rst = |(msk_rst & {2'b00, swp.rst, evi.rst});
    ctl.str = |(msk_str & {2'b00, swp.str, evi.str});
    ctl.stp = |(msk_stp & {2'b00, swp.stp, evi.stp});
    // no trigger source selected, so start fires the trigger itself
    ctl.trg = |(msk_trg & {2'b00, swp.trg, evi.trg}) | (ctl.str & ~|msk_trg);
  end

  assign evo = '{lst: lst, per: per, trg: swp.trg, stp: swp.stp,
                 str: swp.str, rst: swp.rst};

  ////////////////////
  // interrupts
  ////////////////////

  // write 1s to clear
  assign irq_clr = (reg_wen && (reg_addr == `GEN_A_IST)) ? reg_wdata[4-1:0] : 4'h0;

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq_sts <= '0;
    end else if (ctl.rst) begin
      irq_sts <= '0;
    end else begin
      // a new event wins over a clear in the same cycle
      irq_sts <= (irq_sts & ~irq_clr) | ctl;
    end
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      irq <= 1'b0;
    end else begin
      irq <= |(irq_sts & irq_ena);
    end
  end

endmodule

/* logic/gen_table_rd.sv */
/*
 * table reader of the generator channel
 * sample memory, phase accumulator, burst FSM
 * and the two stage raw sample stream
 */
`timescale 1ns/1ps
`include "gen_params.svh"

module gen_table_rd (
  input  logic                bus,
  input  logic                ctl_rst,
  input  gen_pkg::gen_cfg_t   cfg,
  input  gen_pkg::gen_evt_t   ctl,
  // table write port
  input  logic                tbl_wen,
  input  logic [`GEN_CWM-1:0] tbl_addr,
  input  gen_pkg::gen_smp_t   tbl_wdata,
  // raw stream
  output logic                raw_valid,
  output gen_pkg::gen_stm_t   raw,
  input  logic                raw_ready,
  // status and events
  output gen_pkg::gen_sts_t   sts,
  output logic                per,
  output logic                lst
);
  import gen_pkg::*;

  typedef enum logic [1:0] {st_idle, st_arm, st_dat, st_gap} state_t;

  state_t              state;
  gen_smp_t            mem [0:(1<<`GEN_CWM)-1];
  // phase accumulator
  logic [`GEN_CW-1:0]  ptr;
  logic [`GEN_CW-1:0]  cur;
  logic [`GEN_CW-1:0]  nxt;
  logic [`GEN_CW:0]    sum;
  logic                wrap;
  // burst counters
  logic [`GEN_CWM-1:0] bdc;
  logic [`GEN_CWM-1:0] bdc_c;
  logic [`GEN_CWL-1:0] bln_cnt;
  logic [`GEN_CWN-1:0] bnm_cnt;
  logic [`GEN_CWN-1:0] bnm_c;
  // control
  logic                halt;
  logic                go;
  logic                first;
  logic                bst_end;
  logic                fin;
  logic                ld;
  // pipeline
  logic                s1_en;
  logic                s2_en;
  logic                adr_vld;
  logic                adr_lst;
  logic [`GEN_CWM-1:0] adr;

  ////////////////////
  // control
  ////////////////////

  assign halt = ctl.rst | ctl.stp;
  // trigger needs an armed engine, or a start in the same cycle
  assign go = ctl.trg & ~halt & ((state == st_arm) | ((state == st_idle) & ctl.str));

  // first load of a run starts from the phase offset
  assign first = (state != st_dat);
  assign cur   = first ? cfg.off : ptr;
  assign bdc_c = first ? '0 : bdc;
  assign bnm_c = first ? '0 : bnm_cnt;

  // step, then fold back into [0, siz)
  assign sum  = {1'b0, cur} + {1'b0, cfg.ste};
  assign wrap = (sum >= {1'b0, cfg.siz});
  assign nxt  = sum[`GEN_CW-1:0] - (wrap ? cfg.siz : '0);

  // bdl of 0 gives the full 1024 samples
  assign bst_end = cfg.ben & (bdc_c == cfg.bdl - 1'b1);
  assign fin     = bst_end & ~cfg.inf & (bnm_c + 1'b1 == cfg.bnm);

  // address stage loads when empty or being taken
  assign s2_en = ~raw_valid | raw_ready;
  assign s1_en = ~adr_vld | s2_en;
  assign ld    = s1_en & ~halt & (go | (state == st_dat));

  assign per = ld & (cfg.ben ? bst_end : wrap);
  assign lst = ld & fin;

  assign sts = '{run: (state == st_dat) | (state == st_gap),
                 trg: (state == st_arm),
                 bln: bln_cnt,
                 bnm: bnm_cnt};

  // run FSM
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      state <= st_idle;
    end else if (halt) begin
      state <= st_idle;
    end else if (ld & bst_end) begin
      if (fin) begin
        state <= st_idle;
      end else if (cfg.bln == '0) begin
        state <= st_dat;
      end else begin
        state <= st_gap;
      end
    end else if (go) begin
      state <= st_dat;
    end else if ((state == st_idle) & ctl.str) begin
      state <= st_arm;
    end else if ((state == st_gap) & (bln_cnt == cfg.bln - 1'b1)) begin
      state <= st_dat;
    end
  end

  // accumulator and burst counters
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      ptr     <= '0;
      bdc     <= '0;
      bnm_cnt <= '0;
      bln_cnt <= '0;
    end else begin
      if (ld) begin
        // each burst restarts at the phase offset
        ptr     <= bst_end ? cfg.off : nxt;
        bdc     <= bst_end ? '0 : bdc_c + 1'b1;
        bnm_cnt <= bnm_c + `GEN_CWN'(bst_end);
      end else if (go) begin
        ptr     <= cfg.off;
        bdc     <= '0;
        bnm_cnt <= '0;
      end
      // idle gap length
      if (go) begin
        bln_cnt <= '0;
      end else if (state == st_gap) begin
        bln_cnt <= (bln_cnt == cfg.bln - 1'b1) ? '0 : bln_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // table and stream
  ////////////////////

  always_ff @(posedge bus) begin
    if (tbl_wen) begin
      mem[tbl_addr] <= tbl_wdata;
    end
  end

  // stage 1, integer part of the phase
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      adr_vld <= 1'b0;
    end else if (s1_en) begin
      adr_vld <= ld;
    end
  end

  always_ff @(posedge bus) begin
    if (ld) begin
      adr     <= cur[`GEN_CW-1:`GEN_CWF];
      adr_lst <= fin;
    end
  end

  // stage 2, synchronous table read
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      raw_valid <= 1'b0;
    end else if (s2_en) begin
      raw_valid <= adr_vld;
    end
  end

  always_ff @(posedge bus) begin
    if (s2_en & adr_vld) begin
      raw.dat <= mem[adr];
      raw.lst <= adr_lst;
    end
  end

endmodule

/* logic/gen_lin.sv */
/*
 * linear output stage
 * gain, offset, saturation and output enable
 */
`timescale 1ns/1ps
`include "gen_params.svh"

module gen_lin (
  input  logic              bus,
  input  logic              ctl_rst,
  input  gen_pkg::gen_cfg_t cfg,
  // input stream
  input  logic              sti_valid,
  input  gen_pkg::gen_stm_t sti,
  output logic              sti_ready,
  // output stream
  output logic              sto_valid,
  output gen_pkg::gen_stm_t sto,
  input  logic              sto_ready
);
  import gen_pkg::*;

  // gain fraction bits
  localparam int FRC = `GEN_MW - 2;
  localparam logic signed [`GEN_MW:0] MAXV = 2**(`GEN_DW-1) - 1;
  localparam logic signed [`GEN_MW:0] MINV = -(2**(`GEN_DW-1));

  logic signed [`GEN_DW+`GEN_MW-1:0] prd;
  logic signed [`GEN_DW+`GEN_MW-1:0] shf;
  logic signed [`GEN_MW:0]           add;
  gen_smp_t                          sat;
  // multiply stage register
  logic                              m_vld;
  logic signed [`GEN_MW-1:0]         m_dat;
  logic                              m_lst;
  logic                              s1_en;
  logic                              s2_en;

  // load when empty or being taken
  assign s2_en     = ~sto_valid | sto_ready;
  assign s1_en     = ~m_vld | s2_en;
  assign sti_ready = s1_en;

  // full product, then drop the gain fraction
  assign prd = $signed(sti.dat) * $signed(cfg.mul);
  assign shf = prd >>> FRC;

  // offset, clip to the sample range, then gate
  assign add = $signed(m_dat) + $signed(cfg.sum);
  always_comb begin
    if (!cfg.ena) begin
      sat = '0;
    end else if (add > MAXV) begin
      sat = MAXV[`GEN_DW-1:0];
    end else if (add < MINV) begin
      sat = MINV[`GEN_DW-1:0];
    end else begin
      sat = add[`GEN_DW-1:0];
    end
  end

  ////////////////////
  // pipeline
  ////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      m_vld     <= 1'b0;
      sto_valid <= 1'b0;
    end else begin
      if (s1_en) m_vld <= sti_valid;
      if (s2_en) sto_valid <= m_vld;
    end
  end

  // product fits in 16 bits after the shift
  always_ff @(posedge bus) begin
    if (s1_en & sti_valid) begin
      m_dat <= shf[`GEN_MW-1:0];
      m_lst <= sti.lst;
    end
  end

  always_ff @(posedge bus) begin
    if (s2_en & m_vld) begin
      sto.dat <= sat;
      sto.lst <= m_lst;
    end
  end

endmodule

/* logic/gen.sv */
/*
 * generator channel top level
 * register block, table reader and linear stage
 */
`timescale 1ns/1ps
`include "gen_params.svh"

module gen (
  input  logic                bus,
  input  logic                ctl_rst,
  // register port
  input  logic                reg_wen,
  input  logic                reg_ren,
  input  logic [`GEN_AW-1:0]  reg_addr,
  input  logic [32-1:0]       reg_wdata,
  output logic [32-1:0]       reg_rdata,
  output logic                reg_ack,
  // table write port
  input  logic                tbl_wen,
  input  logic [`GEN_CWM-1:0] tbl_addr,
  input  gen_pkg::gen_smp_t   tbl_wdata,
  // events and interrupt
  input  gen_pkg::gen_evt_t   evi,
  output gen_pkg::gen_evo_t   evo,
  output logic                irq,
  // DAC stream
  output logic                sto_valid,
  output gen_pkg::gen_stm_t   sto,
  input  logic                sto_ready
);
  import gen_pkg::*;

  gen_cfg_t cfg;
  gen_evt_t ctl;
  gen_sts_t sts;
  logic     per;
  logic     lst;
  // raw samples toward the linear stage
  logic     raw_valid;
  gen_stm_t raw;
  logic     raw_ready;

  gen_regs u_regs (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .reg_wen   (reg_wen),
    .reg_ren   (reg_ren),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .evi       (evi),
    .sts       (sts),
    .per       (per),
    .lst       (lst),
    .cfg       (cfg),
    .ctl       (ctl),
    .evo       (evo),
    .irq       (irq)
  );

  gen_table_rd u_table_rd (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .cfg       (cfg),
    .ctl       (ctl),
    .tbl_wen   (tbl_wen),
    .tbl_addr  (tbl_addr),
    .tbl_wdata (tbl_wdata),
    .raw_valid (raw_valid),
    .raw       (raw),
    .raw_ready (raw_ready),
    .sts       (sts),
    .per       (per),
    .lst       (lst)
  );

  gen_lin u_lin (
    .bus       (bus),
    .ctl_rst   (ctl_rst),
    .cfg       (cfg),
    .sti_valid (raw_valid),
    .sti       (raw),
    .sti_ready (raw_ready),
    .sto_valid (sto_valid),
    .sto       (sto),
    .sto_ready (sto_ready)
  );

endmodule

/* verification/gen_chk.sv */
/*
 * assertions bound to the generator top level
 * stream stability, pulse width, ack timing, reset state
 */
`timescale 1ns/1ps

module gen_chk (
  input logic              bus,
  input logic              ctl_rst,
  input logic              reg_wen,
  input logic              reg_ren,
  input logic              reg_ack,
  input gen_pkg::gen_evo_t evo,
  input logic              irq,
  input logic              sto_valid,
  input gen_pkg::gen_stm_t sto,
  input logic              sto_ready
);
  import gen_pkg::*;

  // stalled beat holds its payload
  a_hold: assert property (@(posedge bus) disable iff (ctl_rst)
    (sto_valid && !sto_ready) |=> (sto_valid && $stable(sto)))
    else $error("stalled output beat changed");

  // software event pulses last one cycle
  a_pulse: assert property (@(posedge bus) disable iff (ctl_rst)
    (evo[3:0] != 4'h0) |=> (evo[3:0] == 4'h0))
    else $error("event pulse longer than one cycle");

  a_ack: assert property (@(posedge bus) disable iff (ctl_rst)
    (reg_wen || reg_ren) |=> reg_ack)
    else $error("request without ack");

  a_noack: assert property (@(posedge bus) disable iff (ctl_rst)
    !(reg_wen || reg_ren) |=> !reg_ack)
    else $error("ack without request");

  a_rst: assert property (@(posedge bus) $fell(ctl_rst) |-> (!sto_valid && !irq))
    else $error("outputs active right after reset");

endmodule

bind gen gen_chk u_chk (.*);

/* verification/gen_tb.sv */
/*
 * testbench for the generator channel
 * clock, reset, watchdog, bus tasks, reference model,
 * compare tasks and the directed tests
 */
`timescale 1ns/1ps
`include "gen_params.svh"

module gen_tb;
  import gen_pkg::*;

  // rough cycle budget: table fill, register test, five runs
  localparam int EXP_CYC = 1100 + 100 + 200 + 200 + 150 + 250 + 250;

  logic               bus;
  logic               ctl_rst;
  logic               reg_wen;
  logic               reg_ren;
  logic [`GEN_AW-1:0] reg_addr;
  logic [31:0]        reg_wdata;
  logic [31:0]        reg_rdata;
  logic               reg_ack;
  logic               tbl_wen;
  logic [`GEN_CWM-1:0] tbl_addr;
  gen_smp_t           tbl_wdata;
  gen_evt_t           evi;
  gen_evo_t           evo;
  logic               irq;
  logic               sto_valid;
  gen_stm_t           sto;
  logic               sto_ready;

  // shadow of the table and collected beats
  gen_smp_t shadow [0:(1<<`GEN_CWM)-1];
  gen_smp_t exp_q [$];
  gen_smp_t got_q [$];
  logic     lst_q [$];
  int       per_cnt;
  int       lst_cnt;

  gen UUT (.*);

  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;
  end

  initial begin
    #(EXP_CYC * 4 * 2);
    fail_stop("the run timed out before all tests finished");
  end

  ////////////////////
  // reporting
  ////////////////////

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic cmp_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) fail_stop($sformatf("MISMATCH %s exp %h got %h", name, exp, got));
  endtask

  task automatic cmp_smp(input string name, input gen_smp_t exp, input gen_smp_t got);
    if (got !== exp) fail_stop($sformatf("MISMATCH %s exp %h got %h", name, exp, got));
  endtask

  task automatic cmp_evt(input string name, input gen_evo_t exp, input gen_evo_t got);
    if (got !== exp) fail_stop($sformatf("MISMATCH %s exp %h got %h", name, exp, got));
  endtask

  ////////////////////
  // bus tasks
  ////////////////////

  task automatic do_reset;
    @(negedge bus);
    ctl_rst   = 1'b1;
    sto_ready = 1'b0;
    evi       = '0;
    repeat (5) @(negedge bus);
    ctl_rst = 1'b0;
  endtask

  // ack must be present exactly one cycle after the request
  task automatic reg_write(input logic [`GEN_AW-1:0] a, input logic [31:0] d);
    @(negedge bus);
    reg_wen   = 1'b1;
    reg_addr  = a;
    reg_wdata = d;
    @(negedge bus);
    reg_wen = 1'b0;
    if (reg_ack !== 1'b1) fail_stop("register write was not acknowledged after one cycle");
  endtask

  task automatic reg_check(input logic [`GEN_AW-1:0] a, input logic [31:0] exp,
                           input string name);
    @(negedge bus);
    reg_ren  = 1'b1;
    reg_addr = a;
    @(negedge bus);
    reg_ren = 1'b0;
    if (reg_ack !== 1'b1) fail_stop("register read was not acknowledged after one cycle");
    cmp_word(name, exp, reg_rdata);
  endtask

  task automatic write_tbl(input int a, input gen_smp_t d);
    @(negedge bus);
    tbl_wen   = 1'b1;
    tbl_addr  = a[`GEN_CWM-1:0];
    tbl_wdata = d;
    shadow[a] = d;
    @(negedge bus);
    tbl_wen = 1'b0;
  endtask

  task automatic fill_table;
    for (int i = 0; i < (1 << `GEN_CWM); i++) begin
      @(negedge bus);
      tbl_wen   = 1'b1;
      tbl_addr  = i[`GEN_CWM-1:0];
      tbl_wdata = gen_smp_t'($urandom);
      shadow[i] = tbl_wdata;
    end
    @(negedge bus);
    tbl_wen = 1'b0;
  endtask

  task automatic pulse_evi(input gen_evt_t e);
    @(negedge bus);
    evi = e;
    @(negedge bus);
    evi = '0;
  endtask

  // reset, program every field, software start with trigger mask clear
  task automatic start_run(input gen_cfg_t c);
    do_reset();
    reg_write(`GEN_A_SIZ, 32'(c.siz));
    reg_write(`GEN_A_OFF, 32'(c.off));
    reg_write(`GEN_A_STE, 32'(c.ste));
    reg_write(`GEN_A_BMD, {30'd0, c.inf, c.ben});
    reg_write(`GEN_A_BDL, 32'(c.bdl));
    reg_write(`GEN_A_BLN, c.bln);
    reg_write(`GEN_A_BNM, 32'(c.bnm));
    reg_write(`GEN_A_MUL, 32'(c.mul));
    reg_write(`GEN_A_SUM, 32'(c.sum));
    reg_write(`GEN_A_ENA, 32'(c.ena));
    reg_write(`GEN_A_MSTR, 32'h2);
    reg_write(`GEN_A_CTL, 32'h2);
  endtask

  // ready changes on the falling edge, beats counted where they transfer
  task automatic collect(input int n, input bit rnd);
    got_q.delete();
    lst_q.delete();
    per_cnt = 0;
    lst_cnt = 0;
    while (got_q.size() < n) begin
      @(negedge bus);
      sto_ready = rnd ? ($urandom_range(3) != 0) : 1'b1;
      #1;
      per_cnt += int'(evo.per);
      lst_cnt += int'(evo.lst);
      if (sto_valid && sto_ready) begin
        got_q.push_back(sto.dat);
        lst_q.push_back(sto.lst);
      end
    end
  endtask

  task automatic quiet(input int n);
    repeat (n) begin
      @(negedge bus);
      if (sto_valid) fail_stop("output stream kept running after it should have stopped");
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // gain with 14 fraction bits, offset, clip, gate
  function automatic gen_smp_t lin_ref(input gen_smp_t s, input gen_cfg_t c);
    longint v;
    longint m;
    m = longint'($signed(c.mul));
    v = (longint'(s) * m) >>> 14;
    v = v + longint'(c.sum);
    if (!c.ena) v = 0;
    else if (v > 8191) v = 8191;
    else if (v < -8192) v = -8192;
    return gen_smp_t'(v);
  endfunction

  function automatic void build_exp(input gen_cfg_t c, input int n);
    logic [`GEN_CW:0] p;
    int               cnt;
    p   = c.off;
    cnt = 0;
    exp_q.delete();
    for (int i = 0; i < n; i++) begin
      exp_q.push_back(lin_ref(shadow[p[`GEN_CW-1:`GEN_CWF]], c));
      cnt++;
      if (c.ben && (cnt == c.bdl)) begin
        // next burst restarts at the phase offset
        cnt = 0;
        p   = c.off;
      end else begin
        p = p + c.ste;
        if (p >= c.siz) p = p - c.siz;
      end
    end
  endfunction

  task automatic check_stream(input int n);
    for (int i = 0; i < n; i++) cmp_smp($sformatf("sto.dat[%0d]", i), exp_q[i], got_q[i]);
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_regs;
    logic [`GEN_AW-1:0] adr [15];
    logic [31:0]        msk [15];
    logic [31:0]        v;
    adr = '{`GEN_A_IEN, `GEN_A_MRST, `GEN_A_MSTR, `GEN_A_MSTP, `GEN_A_MTRG, `GEN_A_SIZ,
            `GEN_A_OFF, `GEN_A_STE, `GEN_A_BMD, `GEN_A_BDL, `GEN_A_BLN, `GEN_A_BNM,
            `GEN_A_MUL, `GEN_A_SUM, `GEN_A_ENA};
    msk = '{32'hf, 32'hf, 32'hf, 32'hf, 32'hf, 32'h3ff_ffff, 32'h3ff_ffff, 32'h3ff_ffff,
            32'h3, 32'h3ff, 32'hffff_ffff, 32'hffff, 32'hffff, 32'h3fff, 32'h1};
    reg_check(`GEN_A_CTL, 32'h0, "ctl after reset");
    for (int i = 0; i < 15; i++) begin
      v = $urandom;
      reg_write(adr[i], v);
      reg_check(adr[i], v & msk[i], $sformatf("reg %h", adr[i]));
    end
  endtask

  task automatic test_sweep;
    gen_cfg_t c;
    c     = '0;
    c.siz = `GEN_CW'(32'h0010_0000);
    c.ste = `GEN_CW'(32'h0001_0000);
    c.mul = 16'h4000;
    c.ena = 1'b1;
    start_run(c);
    collect(40, 1'b1);
    build_exp(c, 40);
    check_stream(40);
    // wraps after phase 15 and 31 at least
    if (per_cnt < 2) fail_stop("per did not pulse at the table wraps");
  endtask

  task automatic test_frac;
    gen_cfg_t c;
    c     = '0;
    c.siz = `GEN_CW'(32'h0014_0000);
    c.off = `GEN_CW'(32'h0003_4000);
    c.ste = `GEN_CW'(32'h0001_8000);
    c.mul = 16'h4000;
    c.ena = 1'b1;
    start_run(c);
    collect(50, 1'b1);
    build_exp(c, 50);
    check_stream(50);
  endtask

  task automatic test_burst;
    gen_cfg_t c;
    c     = '0;
    c.siz = `GEN_CW'(32'h0100_0000);
    c.off = `GEN_CW'(32'h0002_0000);
    c.ste = `GEN_CW'(32'h0001_0000);
    c.ben = 1'b1;
    c.bdl = 10'd5;
    c.bln = 32'd3;
    c.bnm = 16'd3;
    c.mul = 16'h4000;
    c.ena = 1'b1;
    start_run(c);
    collect(15, 1'b0);
    build_exp(c, 15);
    check_stream(15);
    for (int i = 0; i < 15; i++) begin
      cmp_word($sformatf("sto.lst[%0d]", i), 32'(i == 14), 32'(lst_q[i]));
    end
    cmp_word("per pulses", 32'd3, 32'(per_cnt));
    cmp_word("lst pulses", 32'd1, 32'(lst_cnt));
    reg_check(`GEN_A_SBN, 32'd3, "burst number");
    reg_check(`GEN_A_CTL, 32'h0, "ctl after bursts");
    quiet(20);
  endtask

  task automatic test_lin;
    gen_cfg_t c;
    write_tbl(0, 14'sd8000);
    write_tbl(1, -14'sd8000);
    write_tbl(2, 14'sd1000);
    c     = '0;
    c.siz = `GEN_CW'(32'h0003_0000);
    c.ste = `GEN_CW'(32'h0001_0000);
    c.mul = 16'h7fff;
    c.sum = 14'sd100;
    c.ena = 1'b1;
    start_run(c);
    collect(9, 1'b1);
    build_exp(c, 9);
    check_stream(9);
    // gate closed, zeros expected
    c.ena = 1'b0;
    start_run(c);
    collect(6, 1'b1);
    build_exp(c, 6);
    check_stream(6);
  endtask

  task automatic test_events;
    gen_cfg_t c;
    c     = '0;
    c.siz = `GEN_CW'(32'h03e8_0000);
    c.ste = `GEN_CW'(32'h0001_0000);
    do_reset();
    reg_write(`GEN_A_SIZ, 32'(c.siz));
    reg_write(`GEN_A_STE, 32'(c.ste));
    reg_write(`GEN_A_MUL, 32'h4000);
    reg_write(`GEN_A_ENA, 32'h1);
    reg_write(`GEN_A_IEN, 32'hf);
    // start and trigger external, stop software only
    reg_write(`GEN_A_MSTR, 32'h1);
    reg_write(`GEN_A_MTRG, 32'h1);
    reg_write(`GEN_A_MSTP, 32'h2);
    sto_ready = 1'b1;
    pulse_evi(gen_evt_t'{stp: 1'b1, default: 1'b0});
    reg_check(`GEN_A_IST, 32'h0, "ist masked stop");
    cmp_word("irq", 32'h0, 32'(irq));
    pulse_evi(gen_evt_t'{str: 1'b1, default: 1'b0});
    reg_check(`GEN_A_IST, 32'h2, "ist start");
    reg_check(`GEN_A_CTL, 32'h2, "ctl armed");
    cmp_word("irq", 32'h1, 32'(irq));
    pulse_evi(gen_evt_t'{trg: 1'b1, default: 1'b0});
    reg_check(`GEN_A_CTL, 32'h1, "ctl running");
    reg_check(`GEN_A_IST, 32'ha, "ist trigger");
    reg_write(`GEN_A_IST, 32'ha);
    reg_check(`GEN_A_IST, 32'h0, "ist cleared");
    cmp_word("irq", 32'h0, 32'(irq));
    // software trigger pulses evo but is not selected
    reg_write(`GEN_A_CTL, 32'h8);
    cmp_evt("evo", gen_evo_t'{trg: 1'b1, default: 1'b0}, evo);
    reg_check(`GEN_A_IST, 32'h0, "ist sw trigger masked");
    reg_write(`GEN_A_CTL, 32'h4);
    cmp_evt("evo", gen_evo_t'{stp: 1'b1, default: 1'b0}, evo);
    reg_check(`GEN_A_IST, 32'h4, "ist stop");
    reg_check(`GEN_A_CTL, 32'h0, "ctl stopped");
    // let the in-flight beats drain
    repeat (6) @(negedge bus);
    quiet(20);
  endtask

  initial begin
    ctl_rst   = 1'b1;
    reg_wen   = 1'b0;
    reg_ren   = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    tbl_wen   = 1'b0;
    tbl_addr  = '0;
    tbl_wdata = '0;
    evi       = '0;
    sto_ready = 1'b0;
    void'($urandom(32'h6852_2413));
    do_reset();
    fill_table();
    test_regs();
    test_sweep();
    test_frac();
    test_burst();
    test_lin();
    test_events();
    $display("Test OK");
    $finish;
  end

endmodule

/* gen.f */
+incdir+logic
logic/gen_pkg.sv
logic/gen_regs.sv
logic/gen_table_rd.sv
logic/gen_lin.sv
logic/gen.sv
verification/gen_chk.sv
verification/gen_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f gen.f --top-module gen_tb -Mdir obj_dir
	./obj_dir/Vgen_tb

clean:
	rm -rf obj_dir
